// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_debug_unit
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= All checks passed

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== debug_cases.txt ====
// Word 0: number of sessions. Then per session 16 hex words:
// mode (0 run, 1 step), word count, four program word slots, ten dump field values.
00000003
00000000 00000003 24010005 00A21820 AC030004 00000000
00000010 00000003 00000012 24010005 00000044 00000005 00000007 FFFFFFFC 00000A21 0000C0DE
00000001 00000002 8C040004 00852022 00000000 00000000
00000004 00000002 00000008 8C040004 000000F0 80000001 12345678 00000004 00001F40 0000BEEF
00000000 00000004 20080001 20090002 01095020 AD0A0000
0000000C 00000007 00000010 AD0A0000 0000FF00 00000001 00000002 00000003 0000489A 00005A5A

// ==== debug_controller.sv ====
module debug_controller (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic                             i_rx_done,
  input  logic [debug_pkg::byte_width-1:0] i_rx_data,
  input  logic                             i_soft_reset_ack,
  load_if.ctrl                             load,
  dump_if.ctrl                             dump,
  output logic                             o_run_start,
  output logic                             o_step_mode_cmd,
  input  logic                             i_run_done,
  input  logic                             i_halt_seen,
  input  logic                             i_dump_tx_valid,
  input  logic [debug_pkg::byte_width-1:0] i_dump_tx_byte,
  output logic                             o_soft_reset,
  output logic                             o_tx_start,
  output logic [debug_pkg::byte_width-1:0] o_data_tx,
  output logic                             o_tx_from_dump_n
);

  logic [debug_pkg::state_width-1:0] state;
  logic [debug_pkg::state_width-1:0] next_state;
  logic                              rx_done_q;
  logic                              rx_strobe;
  logic [debug_pkg::byte_width-1:0]  rx_byte;
  logic                              is_start_cmd;

  //////////////////////////////////////////////////////////////////////////
  // Received-byte strobe on the falling edge of i_rx_done.
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      rx_done_q <= 1'b0;
      rx_strobe <= 1'b0;
    end else begin
      rx_done_q <= i_rx_done;
      rx_strobe <= rx_done_q & ~i_rx_done;
    end
  end

  always_ff @(posedge i_clock) begin
    if (rx_done_q && !i_rx_done) begin
      rx_byte <= i_rx_data;  // Held stable under the strobe.
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state <= debug_pkg::st_idle;
    end else begin
      state <= next_state;
    end
  end

  assign is_start_cmd = (rx_byte == debug_pkg::cmd_run) || (rx_byte == debug_pkg::cmd_step);

  always_comb begin
    next_state = state;
    case (state)
      debug_pkg::st_idle:
        if (rx_strobe && rx_byte == debug_pkg::cmd_soft_reset) next_state = debug_pkg::st_soft_reset;
      debug_pkg::st_soft_reset:
        if (!i_soft_reset_ack) next_state = debug_pkg::st_wait_ack;  // Ack is active low.
      debug_pkg::st_wait_ack:
        if (rx_strobe && rx_byte == debug_pkg::cmd_load) next_state = debug_pkg::st_load;
      debug_pkg::st_load:
        if (load.load_done) next_state = debug_pkg::st_wait_start;
      debug_pkg::st_wait_start:
        if (rx_strobe && is_start_cmd) next_state = debug_pkg::st_run;
      debug_pkg::st_run:
        if (i_run_done) next_state = debug_pkg::st_dump;
      debug_pkg::st_dump:
        // A continuous run always ends on HALT, so halt_seen covers both modes.
        if (dump.dump_done) begin
          next_state = i_halt_seen ? debug_pkg::st_idle : debug_pkg::st_wait_start;
        end
      default:
        next_state = debug_pkg::st_idle;
    endcase
  end

  assign o_run_start     = (state == debug_pkg::st_wait_start) && rx_strobe && is_start_cmd;
  assign o_step_mode_cmd = (rx_byte == debug_pkg::cmd_step);

  assign load.load_active = (state == debug_pkg::st_load);
  assign load.rx_strobe   = rx_strobe;
  assign load.rx_byte     = rx_byte;

  assign dump.dump_start = (state == debug_pkg::st_run) && i_run_done;
  assign dump.rx_strobe  = rx_strobe;
  assign dump.rx_byte    = rx_byte;

  assign o_soft_reset     = (state != debug_pkg::st_soft_reset);  // Active low.
  assign o_tx_from_dump_n = (state != debug_pkg::st_dump);

  // Transmit mux between the reset ack byte and the dump byte.
  always_comb begin
    if (!o_tx_from_dump_n) begin
      o_tx_start = i_dump_tx_valid;
      o_data_tx  = i_dump_tx_byte;
    end else if (state == debug_pkg::st_wait_ack) begin
      o_tx_start = 1'b1;
      o_data_tx  = debug_pkg::reset_ack_byte;
    end else begin
      o_tx_start = 1'b0;
      o_data_tx  = '0;
    end
  end

endmodule

// ==== debug_if.sv ====
// Byte path from the session controller into the program loader.
interface load_if;

  logic                             load_active;  // Level, high in the load state.
  logic                             rx_strobe;    // One cycle per received byte.
  logic [debug_pkg::byte_width-1:0] rx_byte;
  logic                             load_done;    // Pulse on the HALT word.

  modport ctrl (
    output load_active,
    output rx_strobe,
    output rx_byte,
    input  load_done
  );

  modport loader (
    input  load_active,
    input  rx_strobe,
    input  rx_byte,
    output load_done
  );

endinterface

// Dump start and host acknowledges, controller to dump sequencer.
interface dump_if;

  logic                             dump_start;  // Pulse at the end of a run.
  logic                             rx_strobe;
  logic [debug_pkg::byte_width-1:0] rx_byte;
  logic                             dump_done;   // Pulse after the last ack.

  modport ctrl (
    output dump_start,
    output rx_strobe,
    output rx_byte,
    input  dump_done
  );

  modport seq (
    input  dump_start,
    input  rx_strobe,
    input  rx_byte,
    output dump_done
  );

endinterface

// ==== debug_pkg.sv ====
package debug_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths.
  ////////////////////////////////////////////////////////////////////////////
  localparam int byte_width      = 8;   // Serial byte.
  localparam int word_width      = 32;  // Instruction and database word.
  localparam int prog_addr_width = 11;  // Program memory address.
  localparam int field_sel_width = 4;   // Database select.

  localparam logic [word_width-1:0] halt_word = 32'hFFFF_FFFF;

  // Host command bytes.
  localparam logic [byte_width-1:0] cmd_soft_reset = 8'd0;
  localparam logic [byte_width-1:0] cmd_load       = 8'd1;
  localparam logic [byte_width-1:0] cmd_run        = 8'd3;
  localparam logic [byte_width-1:0] cmd_step       = 8'd7;

  localparam logic [byte_width-1:0] reset_ack_byte = 8'd1;  // Offered until cmd_load.

  ////////////////////////////////////////////////////////////////////////////
  // Dump layout.
  ////////////////////////////////////////////////////////////////////////////
  localparam int dump_field_count = 10;
  localparam int dump_byte_count  = 28;
  localparam logic [byte_width-1:0]      ack_step       = 8'd8;  // Ack code spacing.
  localparam logic [field_sel_width-1:0] field_sel_base = 4'd2;  // Select of field 0.
  localparam logic [field_sel_width-1:0] run_sel        = 4'd1;  // Select while running.

  // One bit per field, set where the field is sent as four bytes.
  // Fields 3, 5, 6 and 7 are the instruction, register A, register B
  // and the sign-extended immediate; the rest are two-byte fields.
  localparam logic [dump_field_count-1:0] field_wide_mask = 10'b00_1110_1000;

  ////////////////////////////////////////////////////////////////////////////
  // Session states.
  ////////////////////////////////////////////////////////////////////////////
  localparam int state_width = 3;
  localparam logic [state_width-1:0] st_idle       = 3'd0;
  localparam logic [state_width-1:0] st_soft_reset = 3'd1;
  localparam logic [state_width-1:0] st_wait_ack   = 3'd2;
  localparam logic [state_width-1:0] st_load       = 3'd3;
  localparam logic [state_width-1:0] st_wait_start = 3'd4;
  localparam logic [state_width-1:0] st_run        = 3'd5;
  localparam logic [state_width-1:0] st_dump       = 3'd6;

  // Database word, as four bytes or as two halfwords.
  typedef union packed {
    logic [3:0][byte_width-1:0] bytes;   // Index 3 is the most significant.
    logic [1:0][2*byte_width-1:0] halves; // Index 0 is the low halfword.
  } debug_word_u;

endpackage

// ==== debug_unit.sv ====
module debug_unit (
  input  logic                                  i_clock,
  input  logic                                  i_reset,
  input  logic                                  i_rx_done,
  input  logic [debug_pkg::byte_width-1:0]      i_rx_data,
  input  logic                                  i_soft_reset_ack,
  input  logic [debug_pkg::word_width-1:0]      i_instruction_fetch,
  input  logic [debug_pkg::word_width-1:0]      i_database,
  output logic                                  o_tx_start,
  output logic [debug_pkg::byte_width-1:0]      o_data_tx,
  output logic                                  o_soft_reset,
  output logic                                  o_prog_write,
  output logic [debug_pkg::prog_addr_width-1:0] o_prog_addr,
  output logic [debug_pkg::word_width-1:0]      o_prog_data,
  output logic                                  o_exec_step_mode,
  output logic                                  o_enable_pc,
  output logic [debug_pkg::field_sel_width-1:0] o_field_sel
);

  logic                             run_start;
  logic                             step_mode_cmd;
  logic                             run_done;
  logic                             halt_seen;
  logic                             dump_tx_valid;
  logic [debug_pkg::byte_width-1:0] dump_tx_byte;

  load_if load_bus ();
  dump_if dump_bus ();

  debug_controller u_controller (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_rx_done        (i_rx_done),
    .i_rx_data        (i_rx_data),
    .i_soft_reset_ack (i_soft_reset_ack),
    .load             (load_bus.ctrl),
    .dump             (dump_bus.ctrl),
    .o_run_start      (run_start),
    .o_step_mode_cmd  (step_mode_cmd),
    .i_run_done       (run_done),
    .i_halt_seen      (halt_seen),
    .i_dump_tx_valid  (dump_tx_valid),
    .i_dump_tx_byte   (dump_tx_byte),
    .o_soft_reset     (o_soft_reset),
    .o_tx_start       (o_tx_start),
    .o_data_tx        (o_data_tx),
    .o_tx_from_dump_n ()
  );

  program_loader u_loader (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .load         (load_bus.loader),
    .o_prog_write (o_prog_write),
    .o_prog_addr  (o_prog_addr),
    .o_prog_data  (o_prog_data)
  );

  run_control u_run (
    .i_clock             (i_clock),
    .i_reset             (i_reset),
    .i_run_start         (run_start),
    .i_step_mode_cmd     (step_mode_cmd),
    .i_instruction_fetch (i_instruction_fetch),
    .o_enable_pc         (o_enable_pc),
    .o_run_done          (run_done),
    .o_step_mode         (o_exec_step_mode),
    .o_halt_seen         (halt_seen)
  );

  dump_sequencer u_dump (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .dump        (dump_bus.seq),
    .i_database  (i_database),
    .o_field_sel (o_field_sel),
    .o_tx_valid  (dump_tx_valid),
    .o_tx_byte   (dump_tx_byte)
  );

endmodule

// ==== debug_unit_assertions.sv ====
module debug_unit_assertions (
  input logic                              i_clock,
  input logic                              i_reset,
  input logic [debug_pkg::state_width-1:0] state,
  input logic                              rx_strobe,
  input logic                              prog_write,
  input logic                              enable_pc,
  input logic                              tx_start
);

  timeunit 1ns;
  timeprecision 1ps;

  logic assert_failed;  // Read by the testbench top.

  initial assert_failed = 1'b0;

  a_write_in_load : assert property (@(posedge i_clock) disable iff (!i_reset)
    prog_write |-> (state == debug_pkg::st_load))
    else begin
      $error("program write outside the load state");
      assert_failed = 1'b1;
    end

  a_no_enable_with_tx : assert property (@(posedge i_clock) disable iff (!i_reset)
    !(enable_pc && tx_start))
    else begin
      $error("PC enable and tx start high together");
      assert_failed = 1'b1;
    end

  a_strobe_one_cycle : assert property (@(posedge i_clock) disable iff (!i_reset)
    rx_strobe |=> !rx_strobe)
    else begin
      $error("received-byte strobe longer than one cycle");
      assert_failed = 1'b1;
    end

endmodule

bind debug_unit debug_unit_assertions u_assert (
  .i_clock    (i_clock),
  .i_reset    (i_reset),
  .state      (u_controller.state),
  .rx_strobe  (u_controller.rx_strobe),
  .prog_write (o_prog_write),
  .enable_pc  (o_enable_pc),
  .tx_start   (o_tx_start)
);

// ==== dump_sequencer.sv ====
module dump_sequencer (
  input  logic                                  i_clock,
  input  logic                                  i_reset,
  dump_if.seq                                   dump,
  input  logic [debug_pkg::word_width-1:0]      i_database,
  output logic [debug_pkg::field_sel_width-1:0] o_field_sel,
  output logic                                  o_tx_valid,
  output logic [debug_pkg::byte_width-1:0]      o_tx_byte
);

  logic                                  active;
  logic [debug_pkg::field_sel_width-1:0] field_idx;
  logic [1:0]                            byte_idx;
  logic [debug_pkg::byte_width-1:0]      ack_code;   // Code expected for the current byte.
  logic [debug_pkg::field_sel_width-1:0] field_sel_q;
  logic                                  done_q;
  logic                                  wide;
  logic                                  last_byte;
  logic                                  last_field;
  logic                                  ack_ok;
  debug_pkg::debug_word_u                data_word;
  logic [2*debug_pkg::byte_width-1:0]    low_half;

  assign wide       = debug_pkg::field_wide_mask[field_idx];
  assign last_byte  = (byte_idx == (wide ? 2'd3 : 2'd1));
  assign last_field = (field_idx == debug_pkg::field_sel_width'(debug_pkg::dump_field_count - 1));
  assign ack_ok     = active && dump.rx_strobe && (dump.rx_byte == ack_code);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      active      <= 1'b0;
      field_idx   <= '0;
      byte_idx    <= 2'd0;
      ack_code    <= '0;
      field_sel_q <= '0;
      done_q      <= 1'b0;
    end else begin
      done_q <= ack_ok && last_byte && last_field;
      if (dump.dump_start) begin
        active      <= 1'b1;
        field_idx   <= '0;
        byte_idx    <= 2'd0;
        ack_code    <= debug_pkg::ack_step;
        field_sel_q <= debug_pkg::field_sel_base;
      end else if (ack_ok) begin
        ack_code <= ack_code + debug_pkg::ack_step;  // Wraps modulo 256.
        if (!last_byte) begin
          byte_idx <= byte_idx + 2'd1;
        end else begin
          byte_idx <= 2'd0;
          if (last_field) begin
            active <= 1'b0;
          end else begin
            field_idx   <= field_idx + 1'b1;
            field_sel_q <= field_sel_q + 1'b1;
          end
        end
      end else if (!active && dump.rx_strobe) begin
        field_sel_q <= debug_pkg::run_sel;  // A host command always precedes a run.
      end
    end
  end

  // Wide fields MSB first, short fields from the low halfword, high byte first.
  always_comb begin
    data_word = i_database;
    low_half  = data_word.halves[0];
    if (wide) begin
      o_tx_byte = data_word.bytes[2'd3 - byte_idx];
    end else if (byte_idx[0]) begin
      o_tx_byte = low_half[debug_pkg::byte_width-1:0];
    end else begin
      o_tx_byte = low_half[2*debug_pkg::byte_width-1:debug_pkg::byte_width];
    end
  end

  assign o_tx_valid     = active;  // Byte stays offered until its ack.
  assign o_field_sel    = field_sel_q;
  assign dump.dump_done = done_q;

endmodule

// ==== program_loader.sv ====
module program_loader (
  input  logic                                  i_clock,
  input  logic                                  i_reset,
  load_if.loader                                load,
  output logic                                  o_prog_write,
  output logic [debug_pkg::prog_addr_width-1:0] o_prog_addr,
  output logic [debug_pkg::word_width-1:0]      o_prog_data
);

  logic [debug_pkg::word_width-1:0]      word_q;
  logic [1:0]                            byte_cnt;    // Bytes within the word.
  logic                                  word_ready;  // Fourth byte just shifted in.
  logic [debug_pkg::prog_addr_width-1:0] addr_q;
  logic                                  is_halt;

  // First byte ends up most significant.
  always_ff @(posedge i_clock) begin
    if (load.load_active && load.rx_strobe) begin
      word_q <= {word_q[debug_pkg::word_width-debug_pkg::byte_width-1:0], load.rx_byte};
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      byte_cnt   <= 2'd0;
      word_ready <= 1'b0;
      addr_q     <= '0;
    end else if (!load.load_active) begin
      byte_cnt   <= 2'd0;  // Fresh program on the next load.
      word_ready <= 1'b0;
      addr_q     <= '0;
    end else begin
      word_ready <= load.rx_strobe && (byte_cnt == 2'd3);
      if (load.rx_strobe) begin
        byte_cnt <= byte_cnt + 2'd1;  // Wraps after four bytes.
      end
      if (o_prog_write) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  assign is_halt = (word_q == debug_pkg::halt_word);

  // HALT ends the load and is not written.
  assign o_prog_write   = word_ready && !is_halt;
  assign load.load_done = word_ready && is_halt;
  assign o_prog_addr    = addr_q;
  assign o_prog_data    = word_q;

endmodule

// ==== run_control.sv ====
module run_control (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic                             i_run_start,
  input  logic                             i_step_mode_cmd,
  input  logic [debug_pkg::word_width-1:0] i_instruction_fetch,
  output logic                             o_enable_pc,
  output logic                             o_run_done,
  output logic                             o_step_mode,
  output logic                             o_halt_seen
);

  logic running;
  logic stepped;   // The single step enable has been given.
  logic at_halt;

  assign at_halt = (i_instruction_fetch == debug_pkg::halt_word);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      running     <= 1'b0;
      stepped     <= 1'b0;
      o_step_mode <= 1'b0;
      o_halt_seen <= 1'b0;
    end else if (i_run_start) begin
      running     <= 1'b1;
      stepped     <= 1'b0;
      o_step_mode <= i_step_mode_cmd;  // Mode held for the whole run.
      o_halt_seen <= 1'b0;
    end else begin
      if (o_run_done) begin
        running <= 1'b0;
      end else if (running && o_step_mode) begin
        stepped <= 1'b1;
      end
      if (running && at_halt) begin
        o_halt_seen <= 1'b1;  // Kept until the next start.
      end
    end
  end

  // Continuous mode stops in the HALT cycle, step mode after one enable.
  assign o_enable_pc = running && (o_step_mode ? !stepped : !at_halt);
  assign o_run_done  = running && (o_step_mode ? stepped : at_halt);

endmodule

// ==== sources.f ====
debug_pkg.sv
debug_if.sv
debug_controller.sv
program_loader.sv
run_control.sv
dump_sequencer.sv
debug_unit.sv
debug_unit_assertions.sv
tb_debug_unit.sv

// ==== tb_debug_unit.sv ====
module tb_debug_unit;

  timeunit 1ns;
  timeprecision 1ps;

  logic                                  i_clock;
  logic                                  i_reset;
  logic                                  i_rx_done;
  logic [debug_pkg::byte_width-1:0]      i_rx_data;
  logic                                  i_soft_reset_ack;
  logic [debug_pkg::word_width-1:0]      i_instruction_fetch;
  logic [debug_pkg::word_width-1:0]      i_database;
  logic                                  o_tx_start;
  logic [debug_pkg::byte_width-1:0]      o_data_tx;
  logic                                  o_soft_reset;
  logic                                  o_prog_write;
  logic [debug_pkg::prog_addr_width-1:0] o_prog_addr;
  logic [debug_pkg::word_width-1:0]      o_prog_data;
  logic                                  o_exec_step_mode;
  logic                                  o_enable_pc;
  logic [debug_pkg::field_sel_width-1:0] o_field_sel;

  logic [31:0] cases_mem [0:63];                 // Session count followed by 16 words per session.
  logic [debug_pkg::word_width-1:0] prog_mem [0:15];
  logic [debug_pkg::word_width-1:0] field_val [0:9];
  logic [7:0] lfsr;
  int unsigned budget_cycles = 0;
  int pc_model;
  int ack_wait;
  int ack_count   = 0;
  int wr_total    = 0;
  int wr_base     = 0;
  int write_limit = 0;
  int enable_total = 0;

  debug_unit u_dut (.*);

  always #20 i_clock = ~i_clock;

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_byte(input string what, input logic [debug_pkg::byte_width-1:0] got,
                            input logic [debug_pkg::byte_width-1:0] exp);
    if (got !== exp) begin
      $display("error %0t: %s got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_write(input logic [debug_pkg::prog_addr_width-1:0] got_addr,
                             input logic [debug_pkg::word_width-1:0] got_data,
                             input logic [debug_pkg::prog_addr_width-1:0] exp_addr,
                             input logic [debug_pkg::word_width-1:0] exp_data);
    if (got_addr !== exp_addr || got_data !== exp_data) begin
      $display("error %0t: program write %h:%h expected %h:%h", $time,
               got_addr, got_data, exp_addr, exp_data);
      abort_run();
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %0t: %s got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_sel(input logic [debug_pkg::field_sel_width-1:0] got,
                           input logic [debug_pkg::field_sel_width-1:0] exp);
    if (got !== exp) begin
      $display("error %0t: field select got %0d expected %0d", $time, got, exp);
      abort_run();
    end
  endtask

  // Galois LFSR with taps 8'hB8.
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v    = (v << 1) | lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Fields 3, 5, 6 and 7 carry four bytes, the others two.
  function automatic int field_len(input int k);
    field_len = (k == 3 || k == 5 || k == 6 || k == 7) ? 4 : 2;
  endfunction

  function automatic logic [7:0] expected_dump_byte(input int n);
    int pos;
    int len;
    logic [7:0] b;
    pos = n;
    b   = 8'h00;
    for (int k = 0; k < 10; k++) begin
      len = field_len(k);
      if (pos >= 0 && pos < len) begin
        b = field_val[k][8*(len-1-pos) +: 8];  // Most significant byte first.
      end
      pos = pos - len;
    end
    return b;
  endfunction

  // Host serial port sends one byte as a pulse of i_rx_done.
  task automatic send_byte(input logic [7:0] b);
    int gap;
    @(posedge i_clock);
    i_rx_data <= b;
    i_rx_done <= 1'b1;
    @(posedge i_clock);
    i_rx_done <= 1'b0;
    take_bits(2, gap);
    repeat (3 + gap) @(posedge i_clock);
  endtask

  // Processor model with reset ack, PC and fetch, and a registered database lookup.
  always @(posedge i_clock) begin
    if (!o_soft_reset) begin
      pc_model            <= 0;
      i_instruction_fetch <= prog_mem[0];
      if (ack_wait == 5) begin
        i_soft_reset_ack <= 1'b0;  // Ack is active low.
        ack_count        <= ack_count + 1;
        ack_wait         <= 6;
      end else if (ack_wait < 5) begin
        ack_wait <= ack_wait + 1;
      end
    end else begin
      ack_wait         <= 0;
      i_soft_reset_ack <= 1'b1;
      if (o_enable_pc && i_instruction_fetch != debug_pkg::halt_word) begin
        pc_model            <= pc_model + 1;
        i_instruction_fetch <= prog_mem[pc_model+1];
      end
    end
    if (o_field_sel >= 2 && o_field_sel < 12) begin
      i_database <= field_val[o_field_sel-2];
    end else begin
      i_database <= '0;
    end
  end

  always @(negedge i_clock) begin
    if (i_reset && o_prog_write) begin
      if (wr_total - wr_base >= write_limit) begin
        $display("program write seen beyond the end of the program");
        abort_run();
      end
      check_write(o_prog_addr, o_prog_data, (wr_total - wr_base), prog_mem[wr_total-wr_base]);
      wr_total <= wr_total + 1;
    end
    if (o_enable_pc) begin
      enable_total <= enable_total + 1;
    end
    if (u_dut.u_assert.assert_failed) begin
      $display("a bound assertion failed");
      abort_run();
    end
  end

  // Watchdog sized once the cases are read.
  initial begin
    wait (budget_cycles != 0);
    repeat (budget_cycles) @(posedge i_clock);
    $display("watchdog expired, the DUT stopped responding");
    abort_run();
  end

  task automatic run_once(input logic [7:0] cmd, input int exp_enables, input logic step);
    int start;
    int wrong;
    logic [7:0] code;
    start = enable_total;
    send_byte(cmd);
    code = debug_pkg::ack_step;
    for (int n = 0; n < debug_pkg::dump_byte_count; n++) begin
      @(negedge i_clock);
      while (!o_tx_start) @(negedge i_clock);
      if (n == 0) begin
        check_level("step mode", o_exec_step_mode, step);
        if (enable_total - start != exp_enables) begin
          $display("wrong number of PC enable cycles before the dump");
          abort_run();
        end
        @(negedge i_clock);  // Database lookup follows the first select a cycle later.
      end
      check_byte("dump byte", o_data_tx, expected_dump_byte(n));
      take_bits(1, wrong);
      if (wrong != 0) begin
        send_byte(code + 8'd1);  // Wrong code leaves the same byte offered.
        @(negedge i_clock);
        check_level("tx start after wrong ack", o_tx_start, 1'b1);
        check_byte("dump byte after wrong ack", o_data_tx, expected_dump_byte(n));
      end
      send_byte(code);
      code = code + debug_pkg::ack_step;
    end
    @(negedge i_clock);
    check_level("tx start after the last ack", o_tx_start, 1'b0);
  endtask

  task automatic run_session(input int s);
    int base;
    int nwords;
    int acks;
    base   = 1 + s * 16;
    nwords = cases_mem[base+1];
    for (int i = 0; i < 16; i++) begin
      prog_mem[i] = (i < nwords) ? cases_mem[base+2+i] : debug_pkg::halt_word;
    end
    for (int k = 0; k < 10; k++) begin
      field_val[k] = cases_mem[base+6+k];
    end
    acks = ack_count;
    send_byte(debug_pkg::cmd_soft_reset);
    @(negedge i_clock);
    while (ack_count == acks || !o_soft_reset) @(negedge i_clock);
    check_level("tx start in wait ack", o_tx_start, 1'b1);
    check_byte("reset ack byte", o_data_tx, debug_pkg::reset_ack_byte);
    wr_base     = wr_total;
    write_limit = nwords;
    send_byte(debug_pkg::cmd_load);
    for (int i = 0; i <= nwords; i++) begin
      for (int j = 3; j >= 0; j--) begin
        send_byte(prog_mem[i][8*j +: 8]);
      end
    end
    if (wr_total - wr_base != nwords) begin
      $display("program write count does not match the program length");
      abort_run();
    end
    if (cases_mem[base] == 0) begin
      run_once(debug_pkg::cmd_run, nwords, 1'b0);
    end else begin
      for (int st = 0; st < nwords; st++) begin
        run_once(debug_pkg::cmd_step, 1, 1'b1);  // Last step lands on HALT.
      end
    end
  endtask

  initial begin
    int sessions;
    int sends;
    i_clock             = 1'b0;
    i_reset             = 1'b0;
    i_rx_done           = 1'b0;
    i_rx_data           = '0;
    i_soft_reset_ack    = 1'b1;
    i_instruction_fetch = debug_pkg::halt_word;
    i_database          = '0;
    lfsr                = 8'd48;
    $readmemh("debug_cases.txt", cases_mem);
    sessions = cases_mem[0];
    sends    = 0;
    for (int s = 0; s < sessions; s++) begin
      sends += 2 + 4 * (cases_mem[2+s*16] + 1);
      sends += (cases_mem[1+s*16] == 0 ? 1 : cases_mem[2+s*16]) * 57;
    end
    budget_cycles = sends * 12 + sessions * 100 + 200;
    repeat (8) @(posedge i_clock);
    i_reset <= 1'b1;
    @(negedge i_clock);
    check_level("soft reset after reset", o_soft_reset, 1'b1);
    check_level("tx start after reset", o_tx_start, 1'b0);
    check_level("prog write after reset", o_prog_write, 1'b0);
    check_level("pc enable after reset", o_enable_pc, 1'b0);
    check_sel(o_field_sel, '0);
    for (int s = 0; s < sessions; s++) begin
      run_session(s);
    end
    repeat (4) @(posedge i_clock);
    if (u_dut.u_assert.assert_failed) begin
      abort_run();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule
